/* source/rtc_pkg.sv */
package rtc_pkg;

    typedef logic [7:0] rtc_byte_t;   // chip command or data byte
    typedef logic [2:0] host_addr_t;  // host register index

    // host register map
    localparam host_addr_t REG_CMD    = 3'd0;
    localparam host_addr_t REG_SEC    = 3'd1;
    localparam host_addr_t REG_MIN    = 3'd2;
    localparam host_addr_t REG_HOUR   = 3'd3;
    localparam host_addr_t REG_STATUS = 3'd4;

    // opcodes written to REG_CMD
    localparam rtc_byte_t CMD_SET_TIME   = 8'h01;
    localparam rtc_byte_t CMD_FETCH_TIME = 8'h02;

    // chip command bytes, write form (read form has bit 0 set)
    localparam rtc_byte_t CHIP_SEC  = 8'h80;
    localparam rtc_byte_t CHIP_MIN  = 8'h82;
    localparam rtc_byte_t CHIP_HOUR = 8'h84;
    localparam rtc_byte_t CHIP_WP   = 8'h8E;

    localparam rtc_byte_t WP_ON  = 8'h80;
    localparam rtc_byte_t WP_OFF = 8'h00;

    // serial engine states
    typedef enum logic [2:0] {
        E_IDLE, E_SHIFT_OUT, E_TURN, E_SHIFT_IN, E_END_CE, E_DONE
    } eng_state_t;

    // command sequencer states
    typedef enum logic [2:0] {
        S_IDLE, S_ISSUE, S_WAIT, S_NEXT, S_FINISH
    } seq_state_t;

endpackage

/* source/rtc_xfer_if.sv */
`timescale 1ns/1ps

interface rtc_xfer_if;
    import rtc_pkg::*;

    logic      wr_req;    // level, held until done
    logic      rd_req;    // level, held until done
    rtc_byte_t cmd_byte;
    rtc_byte_t wdata;
    rtc_byte_t rdata;     // valid with done on reads
    logic      done;      // one-cycle pulse

    modport host (
        output wr_req, rd_req, cmd_byte, wdata,
        input  rdata, done
    );

    modport engine (
        input  wr_req, rd_req, cmd_byte, wdata,
        output rdata, done
    );

endinterface

/* source/rtc_ctrl_if.sv */
`timescale 1ns/1ps

interface rtc_ctrl_if;
    import rtc_pkg::*;

    logic       go_set;      // pulse
    logic       go_fetch;    // pulse
    rtc_byte_t  set_sec;
    rtc_byte_t  set_min;
    rtc_byte_t  set_hour;
    logic       busy;
    host_addr_t cap_idx;     // shadow register to load
    rtc_byte_t  cap_data;
    logic       cap_strobe;  // pulse per fetched byte

    modport regs (
        output go_set, go_fetch, set_sec, set_min, set_hour,
        input  busy, cap_idx, cap_data, cap_strobe
    );

    modport seq (
        input  go_set, go_fetch, set_sec, set_min, set_hour,
        output busy, cap_idx, cap_data, cap_strobe
    );

endinterface

/* source/rtc_serial_engine.sv */
`timescale 1ns/1ps

module rtc_serial_engine #(
    parameter int HALF_BIT = 50
) (
    input  logic       clk,
    input  logic       rst_n,
    rtc_xfer_if.engine xfer,
    output logic       sclk,
    output logic       ce,
    output logic       sio_drive,
    output logic       sio_en,
    input  logic       sio_sense
);
    import rtc_pkg::*;

    localparam int CNT_W = (HALF_BIT > 0) ? $clog2(HALF_BIT + 1) : 1;

    eng_state_t       state;
    logic [CNT_W-1:0] cnt;         // cycles within one sclk phase
    logic [3:0]       bit_idx;
    logic             is_rd;
    logic [15:0]      tx_sr;       // data byte above command byte
    rtc_byte_t        rx_byte;
    logic [3:0]       sense_sr;
    logic             sense_deb;
    logic             req;
    logic             shifting;
    logic             phase_end;
    logic [3:0]       last_out;

    assign req       = xfer.wr_req | xfer.rd_req;
    assign shifting  = (state == E_SHIFT_OUT) || (state == E_SHIFT_IN);
    assign phase_end = (cnt == CNT_W'(HALF_BIT));
    assign last_out  = is_rd ? 4'd7 : 4'd15;  // read sends only the command
    assign xfer.rdata = rx_byte;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            cnt <= '0;
        else if (req && shifting)
            cnt <= phase_end ? '0 : cnt + 1'b1;
        else
            cnt <= '0;
    end

    // glitch filter on the sensed line, parked at ones while we drive
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sense_sr  <= 4'b1111;
            sense_deb <= 1'b1;
        end
        else if (sio_en)
        begin
            sense_sr  <= 4'b1111;
            sense_deb <= 1'b1;
        end
        else
        begin
            sense_sr <= {sense_sr[2:0], sio_sense};
            if (&sense_sr)
                sense_deb <= 1'b1;
            else if (~|sense_sr)
                sense_deb <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == E_IDLE && req)
            tx_sr <= {xfer.wdata, xfer.cmd_byte};
        if (state == E_SHIFT_IN && !sclk)
            rx_byte[bit_idx[2:0]] <= sense_deb;  // last sample of the phase wins
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state     <= E_IDLE;
            bit_idx   <= '0;
            is_rd     <= 1'b0;
            sclk      <= 1'b0;
            ce        <= 1'b0;
            sio_drive <= 1'b0;
            sio_en    <= 1'b1;
            xfer.done <= 1'b0;
        end
        else
        begin
            case (state)
                E_IDLE:
                    if (req)
                    begin
                        is_rd   <= xfer.rd_req;
                        bit_idx <= '0;
                        sclk    <= 1'b0;
                        ce      <= 1'b1;
                        sio_en  <= 1'b1;
                        state   <= E_SHIFT_OUT;
                    end
                E_SHIFT_OUT:
                    if (!sclk)
                    begin
                        sio_drive <= tx_sr[bit_idx];  // LSB first
                        if (phase_end)
                            sclk <= 1'b1;
                    end
                    else if (phase_end)
                    begin
                        sclk <= 1'b0;
                        if (bit_idx != last_out)
                            bit_idx <= bit_idx + 1'b1;
                        else if (is_rd)
                        begin
                            bit_idx <= '0;
                            sio_en  <= 1'b0;   // release line, chip drives next
                            state   <= E_TURN;
                        end
                        else
                            state <= E_END_CE;
                    end
                E_TURN:
                    state <= E_SHIFT_IN;
                E_SHIFT_IN:
                    if (!sclk)
                    begin
                        if (phase_end)
                            sclk <= 1'b1;
                    end
                    else if (phase_end)
                    begin
                        sclk <= 1'b0;
                        if (bit_idx == 4'd7)
                            state <= E_END_CE;
                        else
                            bit_idx <= bit_idx + 1'b1;
                    end
                E_END_CE:
                begin
                    ce        <= 1'b0;
                    sio_en    <= 1'b1;
                    sio_drive <= 1'b0;
                    state     <= E_DONE;
                end
                E_DONE:
                    if (!xfer.done)
                        xfer.done <= 1'b1;
                    else
                    begin
                        xfer.done <= 1'b0;  // request drops this cycle
                        state     <= E_IDLE;
                    end
                default:
                    state <= E_IDLE;
            endcase
        end
    end

endmodule

/* source/rtc_sequencer.sv */
`timescale 1ns/1ps

module rtc_sequencer (
    input  logic    clk,
    input  logic    rst_n,
    rtc_ctrl_if.seq ctrl,
    rtc_xfer_if.host xfer
);
    import rtc_pkg::*;

    seq_state_t state;
    logic [2:0] step;
    logic       is_fetch;
    logic [2:0] last_step;
    rtc_byte_t  base_cmd;
    rtc_byte_t  cur_cmd;
    rtc_byte_t  cur_wdata;

    assign last_step = is_fetch ? 3'd2 : 3'd4;

    // ordered chip transactions for the active command
    always_comb
    begin
        cur_wdata = WP_ON;
        case (step)
            3'd0:
            begin
                base_cmd  = is_fetch ? CHIP_SEC : CHIP_WP;
                cur_wdata = WP_OFF;
            end
            3'd1:
            begin
                base_cmd  = is_fetch ? CHIP_MIN : CHIP_SEC;
                cur_wdata = ctrl.set_sec;
            end
            3'd2:
            begin
                base_cmd  = is_fetch ? CHIP_HOUR : CHIP_MIN;
                cur_wdata = ctrl.set_min;
            end
            3'd3:
            begin
                base_cmd  = CHIP_HOUR;
                cur_wdata = ctrl.set_hour;
            end
            default:
                base_cmd = CHIP_WP;       // protect again at the end
        endcase
        cur_cmd = {base_cmd[7:1], is_fetch};  // bit 0 selects read
    end

    always_ff @(posedge clk)
    begin
        if (state == S_ISSUE)
        begin
            xfer.cmd_byte <= cur_cmd;
            xfer.wdata    <= cur_wdata;
        end
        if (state == S_WAIT && xfer.done)
        begin
            ctrl.cap_idx  <= REG_SEC + host_addr_t'(step);
            ctrl.cap_data <= xfer.rdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state           <= S_IDLE;
            step            <= '0;
            is_fetch        <= 1'b0;
            ctrl.busy       <= 1'b0;
            ctrl.cap_strobe <= 1'b0;
            xfer.wr_req     <= 1'b0;
            xfer.rd_req     <= 1'b0;
        end
        else
        begin
            case (state)
                S_IDLE:
                    if (ctrl.go_set || ctrl.go_fetch)
                    begin
                        is_fetch  <= ctrl.go_fetch;
                        step      <= '0;
                        ctrl.busy <= 1'b1;
                        state     <= S_ISSUE;
                    end
                S_ISSUE:
                begin
                    xfer.wr_req <= !is_fetch;
                    xfer.rd_req <= is_fetch;
                    state       <= S_WAIT;
                end
                S_WAIT:
                    if (xfer.done)
                    begin
                        xfer.wr_req     <= 1'b0;
                        xfer.rd_req     <= 1'b0;
                        ctrl.cap_strobe <= is_fetch;
                        state           <= S_NEXT;
                    end
                S_NEXT:
                begin
                    ctrl.cap_strobe <= 1'b0;
                    if (step == last_step)
                        state <= S_FINISH;
                    else
                    begin
                        step  <= step + 1'b1;
                        state <= S_ISSUE;
                    end
                end
                S_FINISH:
                begin
                    ctrl.busy <= 1'b0;
                    state     <= S_IDLE;
                end
                default:
                    state <= S_IDLE;
            endcase
        end
    end

endmodule

/* source/rtc_regs.sv */
`timescale 1ns/1ps

module rtc_regs (
    input  logic                clk,
    input  logic                rst_n,
    input  rtc_pkg::host_addr_t host_addr,
    input  rtc_pkg::rtc_byte_t  host_wdata,
    input  logic                host_wr,
    input  logic                host_rd,
    output rtc_pkg::rtc_byte_t  host_rdata,
    rtc_ctrl_if.regs            ctrl
);
    import rtc_pkg::*;

    rtc_byte_t shadow_sec;
    rtc_byte_t shadow_min;
    rtc_byte_t shadow_hour;
    logic      fetched;       // sticky, set by first captured byte
    logic      cmd_ok;

    // also block while a go pulse is in flight and busy is not yet up
    assign cmd_ok = host_wr && (host_addr == REG_CMD) && !ctrl.busy
                    && !ctrl.go_set && !ctrl.go_fetch;

    always_ff @(posedge clk)
    begin
        if (host_wr && host_addr == REG_SEC)
            ctrl.set_sec <= host_wdata;
        if (host_wr && host_addr == REG_MIN)
            ctrl.set_min <= host_wdata;
        if (host_wr && host_addr == REG_HOUR)
            ctrl.set_hour <= host_wdata;
        if (ctrl.cap_strobe)
        begin
            case (ctrl.cap_idx)
                REG_SEC:  shadow_sec  <= ctrl.cap_data;
                REG_MIN:  shadow_min  <= ctrl.cap_data;
                REG_HOUR: shadow_hour <= ctrl.cap_data;
                default:  ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ctrl.go_set   <= 1'b0;
            ctrl.go_fetch <= 1'b0;
            fetched       <= 1'b0;
            host_rdata    <= '0;
        end
        else
        begin
            ctrl.go_set   <= cmd_ok && (host_wdata == CMD_SET_TIME);
            ctrl.go_fetch <= cmd_ok && (host_wdata == CMD_FETCH_TIME);
            if (ctrl.cap_strobe)
                fetched <= 1'b1;
            if (host_rd)
            begin
                case (host_addr)
                    REG_SEC:    host_rdata <= shadow_sec;
                    REG_MIN:    host_rdata <= shadow_min;
                    REG_HOUR:   host_rdata <= shadow_hour;
                    REG_STATUS: host_rdata <= {6'b0, fetched, ctrl.busy};
                    default:    host_rdata <= '0;
                endcase
            end
        end
    end

endmodule

/* source/rtc_top.sv */
`timescale 1ns/1ps

module rtc_top #(
    parameter int HALF_BIT = 50   // clk cycles per sclk phase, minus one
) (
    input  logic                clk,
    input  logic                rst_n,
    // host bus
    input  rtc_pkg::host_addr_t host_addr,
    input  rtc_pkg::rtc_byte_t  host_wdata,
    input  logic                host_wr,
    input  logic                host_rd,
    output rtc_pkg::rtc_byte_t  host_rdata,
    // chip pins, pad buffer lives outside
    output logic                sclk,
    output logic                ce,
    output logic                sio_drive,
    output logic                sio_en,
    input  logic                sio_sense
);

    rtc_ctrl_if ctrl_if ();
    rtc_xfer_if xfer_if ();

    rtc_regs regs_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_wr    (host_wr),
        .host_rd    (host_rd),
        .host_rdata (host_rdata),
        .ctrl       (ctrl_if.regs)
    );

    rtc_sequencer seq_i (
        .clk   (clk),
        .rst_n (rst_n),
        .ctrl  (ctrl_if.seq),
        .xfer  (xfer_if.host)
    );

    rtc_serial_engine #(
        .HALF_BIT (HALF_BIT)
    ) engine_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .xfer      (xfer_if.engine),
        .sclk      (sclk),
        .ce        (ce),
        .sio_drive (sio_drive),
        .sio_en    (sio_en),
        .sio_sense (sio_sense)
    );

endmodule

/* test/ds1302_model.sv */
`timescale 1ns/1ps

module ds1302_model #(
    parameter int HALF_BIT = 50   // clk cycles per sclk phase, minus one
) (
    input  logic clk,
    input  logic sclk,
    input  logic ce,
    input  logic sio,        // resolved line value
    output logic sio_out     // value the chip puts on the line
);
    logic [7:0] regs [0:31];
    logic [7:0] cmd;
    logic [7:0] wdat;
    logic [7:0] rd_byte;
    logic [4:0] cnt;
    logic [3:0] rd_idx;
    logic       rd_bit;
    logic       glitch;
    logic       glitch_en;
    logic       force_wp;    // WP bit cannot be cleared
    integer     seed;

    initial
    begin
        for (int i = 0; i < 32; i++)
            regs[i] = 8'h00;
        regs[7]   = 8'h80;   // write-protect on at power up
        rd_bit    = 1'b1;
        glitch    = 1'b0;
        glitch_en = 1'b0;
        force_wp  = 1'b0;
        rd_idx    = 4'd0;
        cnt       = 5'd0;
        cmd       = 8'h00;
        seed      = 41;
    end

    assign sio_out = rd_bit ^ glitch;

    task preload(input logic [7:0] s, input logic [7:0] m, input logic [7:0] h);
        regs[0] = s;
        regs[1] = m;
        regs[2] = h;
        regs[7] = 8'h80;
    endtask

    // one transaction per ce high period
    always
    begin
        @(posedge ce);
        cnt    = 5'd0;
        rd_idx = 4'd0;
        while (ce)
        begin
            @(posedge sclk or negedge sclk or negedge ce);
            if (ce && sclk)
            begin
                if (cnt < 8)
                    cmd[cnt[2:0]] = sio;       // LSB first
                else if (!cmd[0] && cnt < 16)
                    wdat[cnt[2:0]] = sio;
                cnt = cnt + 1'b1;
                if (cnt == 8 && cmd[0])
                    rd_byte = regs[cmd[5:1]];
                if (cnt == 16 && !cmd[0])
                begin
                    if (cmd[5:1] == 5'd7)
                    begin
                        if (!force_wp)
                            regs[7] = wdat;
                    end
                    else if (!regs[7][7])
                        regs[cmd[5:1]] = wdat; // ignored while protected
                end
            end
            else if (ce && !sclk && cmd[0] && cnt >= 8 && rd_idx < 8)
            begin
                rd_bit = rd_byte[rd_idx[2:0]];
                rd_idx = rd_idx + 1'b1;
            end
        end
        rd_bit = 1'b1;
    end

    // short inversion over the last samples of a low phase
    always @(negedge sclk)
    begin
        if (glitch_en && ce && cmd[0] && cnt >= 8 && $random(seed) % 2 != 0)
        begin
            repeat (HALF_BIT) @(negedge clk);
            glitch = 1'b1;
            repeat (2) @(negedge clk);
            glitch = 1'b0;
        end
    end

endmodule

/* test/tb_rtc_top.sv */
`timescale 1ns/1ps

module tb_rtc_top;
    import rtc_pkg::*;

    localparam int HALF_BIT = 6;

    logic       clk;
    logic       rst_n;
    host_addr_t host_addr;
    rtc_byte_t  host_wdata;
    logic       host_wr;
    logic       host_rd;
    rtc_byte_t  host_rdata;
    logic       sclk;
    logic       ce;
    logic       sio_drive;
    logic       sio_en;
    logic       sio_sense;
    logic       chip_out;
    int         errors;
    int         checks;
    int         n_ops;

    assign sio_sense = sio_en ? sio_drive : chip_out;  // bus resolution

    rtc_top #(.HALF_BIT(HALF_BIT)) dut_i (
        .clk(clk), .rst_n(rst_n),
        .host_addr(host_addr), .host_wdata(host_wdata),
        .host_wr(host_wr), .host_rd(host_rd), .host_rdata(host_rdata),
        .sclk(sclk), .ce(ce), .sio_drive(sio_drive),
        .sio_en(sio_en), .sio_sense(sio_sense)
    );

    ds1302_model #(.HALF_BIT(HALF_BIT)) model_i (
        .clk(clk), .sclk(sclk), .ce(ce), .sio(sio_sense), .sio_out(chip_out)
    );

    always #20 clk = ~clk;

    task check(input logic [7:0] actual, input logic [7:0] expected, input string what);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("ERROR at %0t: %s got %h expected %h", $time, what, actual, expected);
        end
    endtask

    task host_write(input host_addr_t a, input rtc_byte_t d);
        @(posedge clk);
        host_addr  <= a;
        host_wdata <= d;
        host_wr    <= 1'b1;
        @(posedge clk);
        host_wr    <= 1'b0;
    endtask

    task host_read(input host_addr_t a, output rtc_byte_t d);
        @(posedge clk);
        host_addr <= a;
        host_rd   <= 1'b1;
        @(posedge clk);
        host_rd   <= 1'b0;
        @(negedge clk);      // registered data now stable
        d = host_rdata;
    endtask

    task wait_idle;
        rtc_byte_t st;
        host_read(REG_STATUS, st);
        while (st[0])
            host_read(REG_STATUS, st);
    endtask

    task load_time(input rtc_byte_t s, input rtc_byte_t m, input rtc_byte_t h);
        host_write(REG_SEC, s);
        host_write(REG_MIN, m);
        host_write(REG_HOUR, h);
    endtask

    task fetch_and_compare(input rtc_byte_t s, input rtc_byte_t m, input rtc_byte_t h);
        rtc_byte_t v;
        host_write(REG_CMD, CMD_FETCH_TIME);
        wait_idle();
        host_read(REG_SEC, v);
        check(v, s, "seconds");
        host_read(REG_MIN, v);
        check(v, m, "minutes");
        host_read(REG_HOUR, v);
        check(v, h, "hours");
        host_read(REG_STATUS, v);
        check(v[1], 1'b1, "fetched flag");
    endtask

    // watchdog sized from the number of golden operations
    initial
    begin
        @(posedge rst_n);
        #(longint'(n_ops + 1) * 40 * 34 * (HALF_BIT + 1) * 40);
        $display("Timeout: the simulation did not finish in time");
        $display("RESULT: FAIL");
        $finish;
    end

    initial
    begin
        int        fd;
        string     line;
        string     op;
        int        a;
        int        b;
        int        c;
        rtc_byte_t v;
        rtc_byte_t last_sec;

        clk = 1'b0;
        rst_n = 1'b0;
        host_addr = '0;
        host_wdata = '0;
        host_wr = 1'b0;
        host_rd = 1'b0;
        errors = 0;
        checks = 0;
        n_ops = 0;
        last_sec = 8'h00;

        fd = $fopen("test/rtc_golden.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the golden file test/rtc_golden.txt");
            errors++;
        end
        else
        begin
            while ($fgets(line, fd) > 0)
                if (line.len() > 1 && line[0] != "#")
                    n_ops++;
            $fclose(fd);
        end

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check(sclk, 1'b0, "sclk after reset");
        check(ce, 1'b0, "ce after reset");
        check(sio_en, 1'b1, "sio_en after reset");
        check(sio_drive, 1'b0, "sio_drive after reset");
        host_read(REG_STATUS, v);
        check(v, 8'h00, "status after reset");

        fd = $fopen("test/rtc_golden.txt", "r");
        while (fd != 0 && $fgets(line, fd) > 0)
        begin
            if (line.len() > 1 && line[0] != "#")
            begin
                void'($sscanf(line, "%s %h %h %h", op, a, b, c));
                if (op == "P")
                    model_i.preload(a[7:0], b[7:0], c[7:0]);
                else if (op == "S" || op == "W")
                begin
                    model_i.force_wp = (op == "W");
                    load_time(a[7:0], b[7:0], c[7:0]);
                    host_write(REG_CMD, CMD_SET_TIME);
                    wait_idle();
                    model_i.force_wp = 1'b0;
                    check(model_i.regs[7], WP_ON, "model write-protect");
                end
                else if (op == "F")
                begin
                    fetch_and_compare(a[7:0], b[7:0], c[7:0]);
                    last_sec = a[7:0];
                end
                else if (op == "G")
                    model_i.glitch_en = a[0];
                else if (op == "X")
                begin
                    load_time(a[7:0], b[7:0], c[7:0]);
                    host_write(REG_CMD, CMD_SET_TIME);
                    host_read(REG_STATUS, v);
                    check(v[0], 1'b1, "busy during set");
                    host_write(REG_CMD, CMD_FETCH_TIME);  // must be dropped
                    wait_idle();
                    host_read(REG_SEC, v);
                    check(v, last_sec, "shadow after dropped fetch");
                end
                else
                begin
                    $display("Unknown golden opcode %s, line skipped", op);
                    errors++;
                end
            end
        end
        if (fd != 0)
            $fclose(fd);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* test/rtc_golden.txt */
# op sec min hour (hex); P preload, S set, F fetch and expect, W set under forced WP
# X set then fetch while busy, G glitch enable in first field
P 30 15 09
F 30 15 09
S 45 59 23
F 45 59 23
W 11 22 03
F 45 59 23
X 12 34 16
F 12 34 16
G 1 0 0
F 12 34 16
P 01 02 03
F 01 02 03

/* sim.f */
source/rtc_pkg.sv
source/rtc_xfer_if.sv
source/rtc_ctrl_if.sv
source/rtc_serial_engine.sv
source/rtc_sequencer.sv
source/rtc_regs.sv
source/rtc_top.sv
test/ds1302_model.sv
test/tb_rtc_top.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f sim.f --top-module tb_rtc_top -o simv \
    && ./obj_dir/simv | tee /dev/stderr | grep -q "RESULT: PASS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
